// File: rtl/soc_bus_pkg.sv
package soc_bus_pkg;

    // Widths of the internal single word bus
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] paddr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Scratch RAM region, byte addressed
    localparam paddr_t RAM_START = 16'h0000;
    localparam paddr_t RAM_END   = 16'h00FF;

    // Peripheral region behind the APB bridge
    localparam paddr_t UART_START = 16'h1000;
    localparam paddr_t UART_END   = 16'h100F;

    localparam int RAM_WORDS = 64;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    typedef logic [RAM_IDX_W-1:0] ram_idx_t;

endpackage

// File: rtl/uart_pkg.sv
package uart_pkg;

    typedef logic [7:0] uart_byte_t;
    typedef logic [3:0] reg_off_t;

    // Register offsets inside the UART region
    localparam reg_off_t REG_TXDATA = 4'h0;
    localparam reg_off_t REG_RXDATA = 4'h4;
    localparam reg_off_t REG_STATUS = 4'h8;

    // STATUS bit positions
    localparam int STAT_TX_BUSY  = 0;
    localparam int STAT_RX_VALID = 1;

    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
    typedef logic [2:0] bit_idx_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// File: rtl/bus_if.sv
interface bus_if;
    import soc_bus_pkg::*;

    logic   req_valid;
    logic   write;
    paddr_t addr;
    data_t  wdata;
    logic   rsp_valid;
    data_t  rdata;

    modport initiator (
        output req_valid, write, addr, wdata,
        input  rsp_valid, rdata
    );

    modport target (
        input  req_valid, write, addr, wdata,
        output rsp_valid, rdata
    );

endinterface

// File: rtl/apb_if.sv
interface apb_if;
    import soc_bus_pkg::*;
    import uart_pkg::*;

    logic     psel;
    logic     penable;
    logic     pwrite;
    reg_off_t paddr;
    data_t    pwdata;
    data_t    prdata;
    logic     pready;

    modport requester (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready
    );

    modport completer (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );

endinterface

// File: rtl/addr_router.sv
module addr_router (
    input  logic                core_clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  logic                req_write_i,
    input  soc_bus_pkg::paddr_t req_addr_i,
    input  soc_bus_pkg::data_t  req_wdata_i,
    output logic                rsp_valid_o,
    output logic                rsp_err_o,
    output soc_bus_pkg::data_t  rsp_rdata_o,
    bus_if.initiator            ram_o,
    bus_if.initiator            periph_o
);
    import soc_bus_pkg::*;

    logic hit_ram;
    logic hit_uart;
    logic err_q;

    assign hit_ram  = (req_addr_i >= RAM_START) && (req_addr_i <= RAM_END);
    assign hit_uart = (req_addr_i >= UART_START) && (req_addr_i <= UART_END);

    // Request fans out to both targets, only the selected one sees the strobe
    assign ram_o.req_valid = req_valid_i & hit_ram;
    assign ram_o.write     = req_write_i;
    assign ram_o.addr      = req_addr_i;
    assign ram_o.wdata     = req_wdata_i;

    assign periph_o.req_valid = req_valid_i & hit_uart;
    assign periph_o.write     = req_write_i;
    assign periph_o.addr      = req_addr_i;
    assign periph_o.wdata     = req_wdata_i;

    // Unmapped address answers one cycle later with an error
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_valid_i & ~hit_ram & ~hit_uart;
        end
    end

    assign rsp_valid_o = ram_o.rsp_valid | periph_o.rsp_valid | err_q;
    assign rsp_err_o   = err_q;

    always_comb begin
        if (ram_o.rsp_valid) begin
            rsp_rdata_o = ram_o.rdata;
        end else if (periph_o.rsp_valid) begin
            rsp_rdata_o = periph_o.rdata;
        end else begin
            rsp_rdata_o = '0;
        end
    end

endmodule

// File: rtl/scratch_ram.sv
module scratch_ram (
    input  logic  core_clk,
    bus_if.target bus_i
);
    import soc_bus_pkg::*;

    data_t    mem [RAM_WORDS];
    ram_idx_t idx;
    logic     rsp_valid_q;
    data_t    rdata_q;

    // Word index, byte offset bits dropped
    assign idx = bus_i.addr[RAM_IDX_W+1:2];

    always_ff @(posedge core_clk) begin
        if (bus_i.req_valid && bus_i.write) begin
            mem[idx] <= bus_i.wdata;
        end
    end

    // Response follows the request by one cycle, writes return zero
    always_ff @(posedge core_clk) begin
        rsp_valid_q <= bus_i.req_valid;
        if (bus_i.req_valid && !bus_i.write) begin
            rdata_q <= mem[idx];
        end else begin
            rdata_q <= '0;
        end
    end

    assign bus_i.rsp_valid = rsp_valid_q;
    assign bus_i.rdata     = rdata_q;

endmodule

// File: rtl/apb_bridge.sv
module apb_bridge (
    input  logic     core_clk,
    input  logic     rst_n_i,
    bus_if.target    bus_i,
    apb_if.requester apb_o
);
    import soc_bus_pkg::*;
    import uart_pkg::*;

    typedef enum logic [1:0] {BR_IDLE, BR_SETUP, BR_ACCESS} br_state_e;

    br_state_e state_q;
    paddr_t    offset;
    reg_off_t  off_q;
    logic      write_q;
    data_t     wdata_q;
    logic      rsp_valid_q;
    data_t     rdata_q;

    assign offset = bus_i.addr - UART_START;

    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            state_q     <= BR_IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                BR_IDLE: begin
                    if (bus_i.req_valid) begin
                        state_q <= BR_SETUP;
                    end
                end
                BR_SETUP: state_q <= BR_ACCESS;
                BR_ACCESS: begin
                    if (apb_o.pready) begin
                        state_q     <= BR_IDLE;
                        rsp_valid_q <= 1'b1;
                    end
                end
                default: state_q <= BR_IDLE;
            endcase
        end
    end

    // Request fields held for the whole transfer
    always_ff @(posedge core_clk) begin
        if (state_q == BR_IDLE && bus_i.req_valid) begin
            off_q   <= offset[3:0];
            write_q <= bus_i.write;
            wdata_q <= bus_i.wdata;
        end
        if (state_q == BR_ACCESS && apb_o.pready) begin
            rdata_q <= write_q ? '0 : apb_o.prdata;
        end
    end

    assign apb_o.psel    = (state_q == BR_SETUP) || (state_q == BR_ACCESS);
    assign apb_o.penable = (state_q == BR_ACCESS);
    assign apb_o.pwrite  = write_q;
    assign apb_o.paddr   = off_q;
    assign apb_o.pwdata  = wdata_q;

    assign bus_i.rsp_valid = rsp_valid_q;
    assign bus_i.rdata     = rdata_q;

endmodule

// File: rtl/uart_periph.sv
module uart_periph (
    input  logic     core_clk,
    input  logic     rst_n_i,
    apb_if.completer apb_i,
    input  logic     rxd_i,
    output logic     txd_o
);
    import soc_bus_pkg::*;
    import uart_pkg::*;

    localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t HALF_LAST = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

    logic       access;
    logic       tx_write;
    logic       rx_read;
    logic       tx_busy;
    logic       rx_valid_q;

    tx_state_e  tx_state_q;
    baud_cnt_t  tx_cnt_q;
    bit_idx_t   tx_idx_q;
    uart_byte_t tx_shift_q;

    rx_state_e  rx_state_q;
    baud_cnt_t  rx_cnt_q;
    bit_idx_t   rx_idx_q;
    uart_byte_t rx_shift_q;
    uart_byte_t rx_data_q;
    logic       rx_meta_q;
    logic       rx_sync_q;
    logic       rx_done;

    // Register block, acts in the APB access phase
    assign access   = apb_i.psel & apb_i.penable;
    assign tx_write = access & apb_i.pwrite & (apb_i.paddr == REG_TXDATA);
    assign rx_read  = access & ~apb_i.pwrite & (apb_i.paddr == REG_RXDATA);
    assign tx_busy  = (tx_state_q != TX_IDLE);

    assign apb_i.pready = 1'b1;

    always_comb begin
        apb_i.prdata = '0;
        case (apb_i.paddr)
            REG_RXDATA: apb_i.prdata = data_t'(rx_data_q);
            REG_STATUS: begin
                apb_i.prdata[STAT_TX_BUSY]  = tx_busy;
                apb_i.prdata[STAT_RX_VALID] = rx_valid_q;
            end
            default: apb_i.prdata = '0;
        endcase
    end

    // Transmit engine, LSB first
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            tx_state_q <= TX_IDLE;
            tx_cnt_q   <= '0;
            tx_idx_q   <= '0;
        end else if (tx_state_q == TX_IDLE) begin
            tx_cnt_q <= '0;
            tx_idx_q <= '0;
            if (tx_write) begin
                tx_state_q <= TX_START;
            end
        end else if (tx_cnt_q != BIT_LAST) begin
            tx_cnt_q <= tx_cnt_q + 1'b1;
        end else begin
            tx_cnt_q <= '0;
            case (tx_state_q)
                TX_START: tx_state_q <= TX_DATA;
                TX_DATA: begin
                    tx_idx_q <= tx_idx_q + 1'b1;
                    if (tx_idx_q == 3'd7) begin
                        tx_state_q <= TX_STOP;
                    end
                end
                default: tx_state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (tx_state_q == TX_IDLE && tx_write) begin
            tx_shift_q <= apb_i.pwdata[7:0];
        end else if (tx_state_q == TX_DATA && tx_cnt_q == BIT_LAST) begin
            tx_shift_q <= {1'b0, tx_shift_q[7:1]};
        end
    end

    always_comb begin
        case (tx_state_q)
            TX_START: txd_o = 1'b0;
            TX_DATA:  txd_o = tx_shift_q[0];
            default:  txd_o = 1'b1;
        endcase
    end

    // Receive engine, counters sample each bit in its middle
    assign rx_done = (rx_state_q == RX_STOP) && (rx_cnt_q == BIT_LAST);

    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            rx_meta_q  <= 1'b1;
            rx_sync_q  <= 1'b1;
            rx_state_q <= RX_IDLE;
            rx_cnt_q   <= '0;
            rx_idx_q   <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_meta_q <= rxd_i;
            rx_sync_q <= rx_meta_q;
            rx_cnt_q  <= rx_cnt_q + 1'b1;
            case (rx_state_q)
                RX_IDLE: begin
                    rx_cnt_q <= '0;
                    rx_idx_q <= '0;
                    if (!rx_sync_q) begin
                        rx_state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_cnt_q == HALF_LAST) begin
                        rx_cnt_q   <= '0;
                        // Line back high means a glitch, not a start bit
                        rx_state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt_q == BIT_LAST) begin
                        rx_cnt_q <= '0;
                        rx_idx_q <= rx_idx_q + 1'b1;
                        if (rx_idx_q == 3'd7) begin
                            rx_state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (rx_done) begin
                        rx_state_q <= RX_IDLE;
                    end
                end
            endcase
            // A new byte wins over a read in the same cycle
            if (rx_done) begin
                rx_valid_q <= 1'b1;
            end else if (rx_read) begin
                rx_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (rx_state_q == RX_DATA && rx_cnt_q == BIT_LAST) begin
            rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
        end
        if (rx_done) begin
            rx_data_q <= rx_shift_q;
        end
    end

endmodule

// File: rtl/soc_periph_top.sv
module soc_periph_top (
    input  logic                core_clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  logic                req_write_i,
    input  soc_bus_pkg::paddr_t req_addr_i,
    input  soc_bus_pkg::data_t  req_wdata_i,
    output logic                rsp_valid_o,
    output soc_bus_pkg::data_t  rsp_rdata_o,
    output logic                rsp_err_o,
    input  logic                rxd_i,
    output logic                txd_o
);

    bus_if ram_bus ();
    bus_if bridge_bus ();
    apb_if uart_apb ();

    addr_router u_addr_router (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_err_o   (rsp_err_o),
        .rsp_rdata_o (rsp_rdata_o),
        .ram_o       (ram_bus.initiator),
        .periph_o    (bridge_bus.initiator)
    );

    scratch_ram u_scratch_ram (
        .core_clk (core_clk),
        .bus_i    (ram_bus.target)
    );

    apb_bridge u_apb_bridge (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .bus_i    (bridge_bus.target),
        .apb_o    (uart_apb.requester)
    );

    uart_periph u_uart_periph (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .apb_i    (uart_apb.completer),
        .rxd_i    (rxd_i),
        .txd_o    (txd_o)
    );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Released on a rising edge, seen by the DUT one edge later
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: testbench/soc_periph_checker.sv
module soc_periph_checker (
    input logic                core_clk,
    input logic                rst_n_i,
    input logic                req_valid_i,
    input logic                rsp_valid_i,
    input logic                rsp_err_i,
    input logic                txd_i,
    input logic                psel_i,
    input logic                penable_i,
    input uart_pkg::tx_state_e tx_state_i
);
    import uart_pkg::*;

    int unsigned fail_count = 0;
    logic        in_flight_q;

    // One host access outstanding, from request until its response
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            in_flight_q <= 1'b0;
        end else if (req_valid_i) begin
            in_flight_q <= 1'b1;
        end else if (rsp_valid_i) begin
            in_flight_q <= 1'b0;
        end
    end

    penable_with_psel: assert property (
        @(posedge core_clk) disable iff (!rst_n_i) penable_i |-> psel_i
    ) else begin
        $error("APB penable high without psel");
        fail_count = fail_count + 1;
    end

    err_with_valid: assert property (
        @(posedge core_clk) disable iff (!rst_n_i) rsp_err_i |-> rsp_valid_i
    ) else begin
        $error("rsp_err_o high without rsp_valid_o");
        fail_count = fail_count + 1;
    end

    single_outstanding: assert property (
        @(posedge core_clk) disable iff (!rst_n_i) req_valid_i |-> !in_flight_q
    ) else begin
        $error("host request issued while an access is in flight");
        fail_count = fail_count + 1;
    end

    idle_line_high: assert property (
        @(posedge core_clk) disable iff (!rst_n_i) (tx_state_i == TX_IDLE) |-> txd_i
    ) else begin
        $error("txd_o low while the transmitter is idle");
        fail_count = fail_count + 1;
    end

endmodule

bind soc_periph_top soc_periph_checker u_soc_periph_checker (
    .core_clk    (core_clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_err_i   (rsp_err_o),
    .txd_i       (txd_o),
    .psel_i      (uart_apb.psel),
    .penable_i   (uart_apb.penable),
    .tx_state_i  (u_uart_periph.tx_state_q)
);

// File: testbench/tb_soc_periph.sv
module tb_soc_periph;
    import soc_bus_pkg::*;
    import uart_pkg::*;

    typedef enum {OP_WRITE, OP_READ, OP_XFER, OP_RECV} op_e;

    typedef struct {
        string  name;
        op_e    op;
        paddr_t addr;
        data_t  wdata;
        data_t  exp_data;
        logic   exp_err;
    } step_t;

    localparam int     RESET_TIMEOUT = 10;
    localparam int     BUS_TIMEOUT   = 16;
    localparam int     POLL_LIMIT    = 64;
    localparam paddr_t TXDATA_ADDR   = UART_START + paddr_t'(REG_TXDATA);
    localparam paddr_t RXDATA_ADDR   = UART_START + paddr_t'(REG_RXDATA);
    localparam paddr_t STATUS_ADDR   = UART_START + paddr_t'(REG_STATUS);

    logic   core_clk;
    logic   rst_n_i;
    logic   req_valid_i;
    logic   req_write_i;
    paddr_t req_addr_i;
    data_t  req_wdata_i;
    logic   rsp_valid_o;
    data_t  rsp_rdata_o;
    logic   rsp_err_o;
    logic   serial_line;
    step_t  steps[$];
    data_t  lcg_state = 32'd43373;

    tb_clock_gen u_tb_clock_gen (
        .clk_o   (core_clk),
        .rst_n_o (rst_n_i)
    );

    // Serial loopback from txd_o back to rxd_i
    soc_periph_top u_soc_periph_top (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .rxd_i       (serial_line),
        .txd_o       (serial_line)
    );

    function automatic data_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic data_t status_word(input logic tx_busy, input logic rx_valid);
        data_t word;
        word = '0;
        word[STAT_TX_BUSY]  = tx_busy;
        word[STAT_RX_VALID] = rx_valid;
        return word;
    endfunction

    function automatic int unsigned checker_failures();
        return u_soc_periph_top.u_soc_periph_checker.fail_count;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected err %b actual err %b", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %02h actual %02h", name, exp, act));
        end
    endtask

    task automatic check_line(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic add_step(input string name, input op_e op, input paddr_t addr,
                            input data_t wdata, input data_t exp_data, input logic exp_err);
        step_t s;
        s.name     = name;
        s.op       = op;
        s.addr     = addr;
        s.wdata    = wdata;
        s.exp_data = exp_data;
        s.exp_err  = exp_err;
        steps.push_back(s);
    endtask

    // One strobe and then a wait for the single response
    task automatic bus_access(input logic write, input paddr_t addr, input data_t wdata,
                              output data_t rdata, output logic err);
        int unsigned waited;
        waited = 0;
        @(posedge core_clk);
        req_valid_i <= 1'b1;
        req_write_i <= write;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        @(posedge core_clk);
        req_valid_i <= 1'b0;
        while (rsp_valid_o !== 1'b1) begin
            @(posedge core_clk);
            waited++;
            if (waited > BUS_TIMEOUT) begin
                fail_run($sformatf("no response to access at address %04h", addr));
            end
        end
        rdata = rsp_rdata_o;
        err   = rsp_err_o;
    endtask

    task automatic wait_rx_valid(input string name);
        data_t       status;
        logic        err;
        int unsigned polls;
        polls = 0;
        bus_access(1'b0, STATUS_ADDR, '0, status, err);
        while (status[STAT_RX_VALID] !== 1'b1) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_run($sformatf("%s: receiver never reported a byte", name));
            end
            bus_access(1'b0, STATUS_ADDR, '0, status, err);
        end
    endtask

    task automatic receive_byte(input step_t s);
        data_t rdata;
        logic  err;
        wait_rx_valid(s.name);
        bus_access(1'b0, RXDATA_ADDR, '0, rdata, err);
        check_err(s.name, 1'b0, err);
        check_byte(s.name, s.exp_data[7:0], rdata[7:0]);
        // The RXDATA read must have cleared rx_valid
        bus_access(1'b0, STATUS_ADDR, '0, rdata, err);
        check_data({s.name, "_status"}, status_word(1'b0, 1'b0), rdata);
    endtask

    task automatic run_step(input step_t s);
        data_t rdata;
        logic  err;
        case (s.op)
            OP_WRITE, OP_READ: begin
                bus_access(s.op == OP_WRITE, s.addr, s.wdata, rdata, err);
                check_err(s.name, s.exp_err, err);
                check_data(s.name, s.exp_data, rdata);
            end
            OP_XFER: begin
                bus_access(1'b1, s.addr, s.wdata, rdata, err);
                check_err(s.name, s.exp_err, err);
                receive_byte(s);
            end
            default: receive_byte(s);
        endcase
    endtask

    task automatic build_table();
        paddr_t ram_addr[4];
        data_t  ram_data[4];
        data_t  rand_byte;
        ram_addr = '{16'h0000, 16'h0004, 16'h0080, 16'h00FC};
        add_step("status_after_reset", OP_READ, STATUS_ADDR, '0, '0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            ram_data[i] = next_random();
            add_step($sformatf("ram_write_%0d", i), OP_WRITE, ram_addr[i], ram_data[i], '0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_step($sformatf("ram_read_%0d", i), OP_READ, ram_addr[i], '0, ram_data[i], 1'b0);
        end
        // 0x0100 aliases word 0 if the decoder ignores the upper bits
        add_step("err_read_gap", OP_READ, 16'h0100, '0, '0, 1'b1);
        add_step("err_write_gap", OP_WRITE, 16'h0100, next_random(), '0, 1'b1);
        add_step("err_read_past_uart", OP_READ, 16'h1010, '0, '0, 1'b1);
        add_step("err_write_top", OP_WRITE, 16'hFFFC, next_random(), '0, 1'b1);
        add_step("ram_intact_0", OP_READ, ram_addr[0], '0, ram_data[0], 1'b0);
        add_step("ram_intact_3", OP_READ, ram_addr[3], '0, ram_data[3], 1'b0);
        add_step("uart_unused_offset", OP_READ, UART_START + 16'h000C, '0, '0, 1'b0);
        add_step("tx_first_byte", OP_WRITE, TXDATA_ADDR, 32'h0000_00A5, '0, 1'b0);
        add_step("tx_busy_status", OP_READ, STATUS_ADDR, '0, status_word(1'b1, 1'b0), 1'b0);
        add_step("tx_byte_while_busy", OP_WRITE, TXDATA_ADDR, 32'h0000_003C, '0, 1'b0);
        add_step("rx_first_byte_only", OP_RECV, RXDATA_ADDR, '0, 32'h0000_00A5, 1'b0);
        add_step("loop_00", OP_XFER, TXDATA_ADDR, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_step("loop_ff", OP_XFER, TXDATA_ADDR, 32'h0000_00FF, 32'h0000_00FF, 1'b0);
        add_step("loop_5a", OP_XFER, TXDATA_ADDR, 32'h0000_005A, 32'h0000_005A, 1'b0);
        add_step("loop_81", OP_XFER, TXDATA_ADDR, 32'h0000_0081, 32'h0000_0081, 1'b0);
        rand_byte = next_random() & 32'h0000_00FF;
        add_step("loop_random", OP_XFER, TXDATA_ADDR, rand_byte, rand_byte, 1'b0);
    endtask

    initial begin
        int unsigned waited;
        req_valid_i <= 1'b0;
        req_write_i <= 1'b0;
        req_addr_i  <= '0;
        req_wdata_i <= '0;
        waited = 0;
        build_table();
        @(posedge core_clk);
        while (rst_n_i !== 1'b1) begin
            @(posedge core_clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                fail_run("reset was never released");
            end
        end
        check_line("reset_txd_idle", 1'b1, serial_line);
        check_line("reset_no_response", 1'b0, rsp_valid_o);
        foreach (steps[i]) begin
            run_step(steps[i]);
            if (checker_failures() != 0) begin
                fail_run($sformatf("bus or APB rule broken during step %s", steps[i].name));
            end
        end
        // Assertions on the last edge report after that edge
        @(posedge core_clk);
        if (checker_failures() != 0) begin
            fail_run("bus or APB rule broken at end of run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: project.f
rtl/soc_bus_pkg.sv
rtl/uart_pkg.sv
rtl/bus_if.sv
rtl/apb_if.sv
rtl/addr_router.sv
rtl/scratch_ram.sv
rtl/apb_bridge.sv
rtl/uart_periph.sv
rtl/soc_periph_top.sv
testbench/tb_clock_gen.sv
testbench/soc_periph_checker.sv
testbench/tb_soc_periph.sv

// File: Bender.yml
package:
  name: soc_periph

sources:
  - rtl/soc_bus_pkg.sv
  - rtl/uart_pkg.sv
  - rtl/bus_if.sv
  - rtl/apb_if.sv
  - rtl/addr_router.sv
  - rtl/scratch_ram.sv
  - rtl/apb_bridge.sv
  - rtl/uart_periph.sv
  - rtl/soc_periph_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/soc_periph_checker.sv
      - testbench/tb_soc_periph.sv
